//--- design/icache_array.sv
`timescale 1ns/1ps

module icache_array import icache_pkg::*; #(
  parameter int unsigned INDEX_W = 2
) (
  input  logic  clock,
  input  logic  reset,
  input  logic  invalidate_i,
  input  addr_t lookup_pc_i,
  output logic  hit_o,
  output word_t hit_data_o,
  input  logic  fill_valid_i,
  input  fill_t fill_i
);

  localparam int unsigned TAG_W = 32 - LINE_OFF_W - INDEX_W;
  localparam int unsigned LINES = 1 << INDEX_W;

  logic [TAG_W-1:0] tag_q [0:LINES-1];
  logic [LINES-1:0] valid_q;
  word_t            data_q [0:LINES-1][0:3];

  logic [INDEX_W-1:0] lookup_idx;
  logic [TAG_W-1:0]   lookup_tag;
  word_sel_t          lookup_sel;

  logic [INDEX_W-1:0] fill_idx;
  logic [TAG_W-1:0]   fill_tag;
  logic               fill_done;

  // split the lookup pc into tag, index and word
  assign lookup_idx = lookup_pc_i[LINE_OFF_W +: INDEX_W];
  assign lookup_tag = lookup_pc_i[31 -: TAG_W];
  assign lookup_sel = lookup_pc_i[3:2];

  assign hit_o      = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
  assign hit_data_o = data_q[lookup_idx][lookup_sel];

  assign fill_idx  = fill_i.line_addr[LINE_OFF_W +: INDEX_W];
  assign fill_tag  = fill_i.line_addr[31 -: TAG_W];
  assign fill_done = fill_valid_i && fill_i.last && !is_uncached(fill_i.line_addr);

  always_ff @(posedge clock) begin
    if (fill_valid_i) begin
      data_q[fill_idx][fill_i.word_sel] <= fill_i.data;
    end
  end

  // tag is written once the whole line is in
  always_ff @(posedge clock) begin
    if (fill_done) begin
      tag_q[fill_idx] <= fill_tag;
    end
  end

  // invalidate beats a finishing fill
  always_ff @(posedge clock) begin
    if (reset || invalidate_i) begin
      valid_q <= '0;
    end else if (fill_done) begin
      valid_q[fill_idx] <= 1'b1;
    end
  end

  // refill must never stream an uncached word into the line storage
  a_no_uncached_fill: assert property (
    @(posedge clock) disable iff (reset)
    fill_valid_i |-> !is_uncached(fill_i.line_addr)
  );

endmodule

//--- design/icache_pkg.sv
package icache_pkg;

  // byte address and instruction word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;

  // word within a four-word line
  typedef logic [1:0] word_sel_t;

  // AXI burst length, beats minus one
  typedef logic [7:0] axi_len_t;

  // 16-byte lines
  localparam int unsigned LINE_OFF_W = 4;

  localparam logic [15:0] UNCACHED_PREFIX = 16'h0f00;

  typedef struct packed {
    addr_t pc;
    addr_t snpc;
  } fetch_req_t;

  typedef struct packed {
    addr_t pc;
    addr_t snpc;
    word_t inst;
  } fetch_rsp_t;

  typedef struct packed {
    addr_t    addr;
    axi_len_t len;
  } axi_ar_t;

  typedef struct packed {
    word_t data;
    logic  last;
  } axi_r_t;

  // one refill beat toward the array
  typedef struct packed {
    addr_t     line_addr;
    word_sel_t word_sel;
    word_t     data;
    logic      last;
  } fill_t;

  function automatic logic is_uncached(addr_t addr);
    return addr[31:16] == UNCACHED_PREFIX;
  endfunction

endpackage

//--- design/icache_refill.sv
`timescale 1ns/1ps

module icache_refill import icache_pkg::*; #(
  parameter int unsigned INDEX_W = 2
) (
  input  logic    clock,
  input  logic    reset,
  input  logic    lookup_valid_i,
  input  addr_t   lookup_pc_i,
  input  logic    hit_i,
  input  logic    consume_i,
  output logic    ar_valid_o,
  output axi_ar_t ar_o,
  input  logic    ar_ready_i,
  input  logic    r_valid_i,
  input  axi_r_t  r_i,
  output logic    r_ready_o,
  output logic    fill_valid_o,
  output fill_t   fill_o,
  output logic    word_valid_o,
  output word_t   word_o,
  output logic    idle_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SEND,
    ST_WAIT,
    ST_RESPOND
  } state_e;

  state_e    state_q;
  state_e    state_d;
  addr_t     miss_addr_q;
  word_sel_t beat_ptr_q;
  word_t     word_q;
  logic      drop_q;

  logic      miss_start;
  logic      uncached;
  logic      beat;

  assign miss_start = (state_q == ST_IDLE) && lookup_valid_i && !hit_i;
  assign uncached   = is_uncached(miss_addr_q);
  assign beat       = r_valid_i && r_ready_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (miss_start) begin
          state_d = ST_SEND;
        end
      end
      ST_SEND: begin
        if (ar_ready_i) begin
          state_d = ST_WAIT;
        end
      end
      ST_WAIT: begin
        // a flushed miss still finishes its burst, then goes quiet
        if (beat && r_i.last) begin
          state_d = (drop_q || consume_i) ? ST_IDLE : ST_RESPOND;
        end
      end
      ST_RESPOND: begin
        if (consume_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= ST_IDLE;
      drop_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (miss_start) begin
        drop_q <= consume_i;
      end else if (consume_i) begin
        drop_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (miss_start) begin
      miss_addr_q <= lookup_pc_i;
      beat_ptr_q  <= lookup_pc_i[3:2];
    end else if (beat) begin
      beat_ptr_q <= beat_ptr_q + 2'd1;
    end
  end

  // hold the requested word until the stage takes it
  always_ff @(posedge clock) begin
    if (beat && (beat_ptr_q == miss_addr_q[3:2])) begin
      word_q <= r_i.data;
    end
  end

  assign ar_valid_o = (state_q == ST_SEND);
  assign ar_o.addr  = miss_addr_q;
  assign ar_o.len   = uncached ? axi_len_t'(0) : axi_len_t'(3);
  assign r_ready_o  = (state_q == ST_WAIT);

  assign fill_valid_o     = beat && !uncached;
  assign fill_o.line_addr = miss_addr_q;
  assign fill_o.word_sel  = beat_ptr_q;
  assign fill_o.data      = r_i.data;
  assign fill_o.last      = r_i.last;

  assign word_valid_o = (state_q == ST_RESPOND);
  assign word_o       = word_q;
  assign idle_o       = (state_q == ST_IDLE);

  a_ar_stable: assert property (
    @(posedge clock) disable iff (reset)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o)
  );

  // memory side must not send data before the address went out
  a_r_in_data_phase: assert property (
    @(posedge clock) disable iff (reset)
    r_valid_i |-> state_q == ST_WAIT
  );

  // wrapping burst ends exactly on the word before the requested one
  a_last_wraps: assert property (
    @(posedge clock) disable iff (reset)
    beat && r_i.last && !uncached |-> beat_ptr_q == miss_addr_q[3:2] - 2'd1
  );

endmodule

//--- design/icache_stage.sv
`timescale 1ns/1ps

module icache_stage import icache_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       req_valid_i,
  input  fetch_req_t req_i,
  output logic       req_ready_o,
  output logic       rsp_valid_o,
  output fetch_rsp_t rsp_o,
  input  logic       rsp_ready_i,
  input  logic       flush_i,
  input  logic       hit_i,
  input  word_t      hit_data_i,
  input  logic       word_valid_i,
  input  word_t      word_i,
  input  logic       refill_idle_i,
  output logic       lookup_valid_o,
  output addr_t      lookup_pc_o,
  output logic       consume_o
);

  fetch_req_t req_q;
  logic       valid_q;

  logic       accept;
  logic       take;

  assign take   = rsp_valid_o && rsp_ready_i;
  assign accept = req_valid_i && req_ready_o;

  // next request may enter as the current response leaves
  assign req_ready_o = (!valid_q || take) && refill_idle_i;

  always_ff @(posedge clock) begin
    if (accept) begin
      req_q <= req_i;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (take || flush_i) begin
      valid_q <= 1'b0;
    end
  end

  assign lookup_valid_o = valid_q;
  assign lookup_pc_o    = req_q.pc;
  assign consume_o      = valid_q && (take || flush_i);

  assign rsp_valid_o = valid_q && (hit_i || word_valid_i);

  // refill word wins over the array once a miss completes
  assign rsp_o.pc   = req_q.pc;
  assign rsp_o.snpc = req_q.snpc;
  assign rsp_o.inst = word_valid_i ? word_i : hit_data_i;

  // a waiting response only changes if an invalidate turns it back into a miss
  a_rsp_stable: assert property (
    @(posedge clock) disable iff (reset)
    rsp_valid_o && !rsp_ready_i && !flush_i |=> !rsp_valid_o || $stable(rsp_o)
  );

endmodule

//--- design/icache_top.sv
`timescale 1ns/1ps

module icache_top import icache_pkg::*; #(
  parameter int unsigned INDEX_W = 2
) (
  input  logic       clock,
  input  logic       reset,

  input  logic       req_valid_i,
  input  fetch_req_t req_i,
  output logic       req_ready_o,

  output logic       rsp_valid_o,
  output fetch_rsp_t rsp_o,
  input  logic       rsp_ready_i,

  input  logic       flush_i,
  input  logic       invalidate_i,

  output logic       ar_valid_o,
  output axi_ar_t    ar_o,
  input  logic       ar_ready_i,
  input  logic       r_valid_i,
  input  axi_r_t     r_i,
  output logic       r_ready_o
);

  logic  hit;
  word_t hit_data;
  logic  lookup_valid;
  addr_t lookup_pc;
  logic  consume;
  logic  fill_valid;
  fill_t fill;
  logic  word_valid;
  word_t word;
  logic  refill_idle;

  icache_stage u_stage (
    .clock          (clock),
    .reset          (reset),
    .req_valid_i    (req_valid_i),
    .req_i          (req_i),
    .req_ready_o    (req_ready_o),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_o          (rsp_o),
    .rsp_ready_i    (rsp_ready_i),
    .flush_i        (flush_i),
    .hit_i          (hit),
    .hit_data_i     (hit_data),
    .word_valid_i   (word_valid),
    .word_i         (word),
    .refill_idle_i  (refill_idle),
    .lookup_valid_o (lookup_valid),
    .lookup_pc_o    (lookup_pc),
    .consume_o      (consume)
  );

  icache_array #(.INDEX_W(INDEX_W)) u_array (
    .clock        (clock),
    .reset        (reset),
    .invalidate_i (invalidate_i),
    .lookup_pc_i  (lookup_pc),
    .hit_o        (hit),
    .hit_data_o   (hit_data),
    .fill_valid_i (fill_valid),
    .fill_i       (fill)
  );

  icache_refill #(.INDEX_W(INDEX_W)) u_refill (
    .clock          (clock),
    .reset          (reset),
    .lookup_valid_i (lookup_valid),
    .lookup_pc_i    (lookup_pc),
    .hit_i          (hit),
    .consume_i      (consume),
    .ar_valid_o     (ar_valid_o),
    .ar_o           (ar_o),
    .ar_ready_i     (ar_ready_i),
    .r_valid_i      (r_valid_i),
    .r_i            (r_i),
    .r_ready_o      (r_ready_o),
    .fill_valid_o   (fill_valid),
    .fill_o         (fill),
    .word_valid_o   (word_valid),
    .word_o         (word),
    .idle_o         (refill_idle)
  );

endmodule

//--- project.f
design/icache_pkg.sv
design/icache_array.sv
design/icache_refill.sv
design/icache_stage.sv
design/icache_top.sv
sim/icache_mem_model.sv
sim/icache_tb.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert --top-module icache_tb -f project.f -o icache_sim \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/icache_sim > sim.log 2>&1
cat sim.log
grep -q "Test failed" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Test passed" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

//--- sim/icache_mem_model.sv
`timescale 1ns/1ps

module icache_mem_model import icache_pkg::*; (
  input  logic    clock,
  input  logic    reset,
  input  logic    ar_valid_i,
  input  axi_ar_t ar_i,
  output logic    ar_ready_o,
  output logic    r_valid_o,
  output axi_r_t  r_o,
  input  logic    r_ready_i
);

  localparam word_t DATA_KEY = 32'h5a5a_0000;

  logic    busy;
  addr_t   cur_addr;
  int      beats_left;
  logic    ar_fire;
  logic    r_fire;
  axi_ar_t ar_req;

  function automatic addr_t next_wrap(addr_t a);
    return {a[31:4], a[3:2] + 2'd1, 2'b00};
  endfunction

  function automatic word_t word_at(addr_t a);
    return {a[31:2], 2'b00} ^ DATA_KEY;
  endfunction

  // handshakes sampled mid-cycle, outputs moved just after the edge
  initial begin
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_o        = '0;
    busy       = 1'b0;
    cur_addr   = '0;
    beats_left = 0;
    forever begin
      @(negedge clock);
      ar_fire = ar_valid_i && ar_ready_o;
      r_fire  = r_valid_o && r_ready_i;
      ar_req  = ar_i;
      @(posedge clock);
      #2;
      if (reset) begin
        busy       = 1'b0;
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
      end else begin
        if (ar_fire) begin
          busy       = 1'b1;
          cur_addr   = ar_req.addr;
          beats_left = int'(ar_req.len) + 1;
        end
        if (r_fire) begin
          beats_left = beats_left - 1;
          cur_addr   = next_wrap(cur_addr);
          r_valid_o  = 1'b0;
          if (beats_left == 0) begin
            busy = 1'b0;
          end
        end
        // random gaps between beats
        if (busy && !r_valid_o && $urandom_range(9) < 6) begin
          r_valid_o  = 1'b1;
          r_o.data   = word_at(cur_addr);
          r_o.last   = (beats_left == 1);
        end
        ar_ready_o = !busy && ($urandom_range(1) == 1);
      end
    end
  end

endmodule

//--- sim/icache_tb.sv
`timescale 1ns/1ps

module icache_tb import icache_pkg::*; ();

  localparam int          INDEX_W          = 2;
  localparam int          TAG_W            = 32 - 4 - INDEX_W;
  localparam int          NUM_FETCHES      = 600;
  localparam int          CYCLES_PER_FETCH = 60;
  localparam int          CLK_PERIOD       = 40;
  localparam logic [15:0] UNCACHED_HI      = 16'h0f00;
  localparam word_t       DATA_KEY         = 32'h5a5a_0000;

  logic       clock;
  logic       reset;
  logic       req_valid;
  fetch_req_t req;
  logic       req_ready;
  logic       rsp_valid;
  fetch_rsp_t rsp;
  logic       rsp_ready;
  logic       flush;
  logic       invalidate;
  logic       ar_valid;
  axi_ar_t    ar;
  logic       ar_ready;
  logic       r_valid;
  axi_r_t     r;
  logic       r_ready;

  // reference model state
  fetch_req_t              pend_q[$];
  logic [(1<<INDEX_W)-1:0] shadow_valid;
  logic [TAG_W-1:0]        shadow_tag [0:(1<<INDEX_W)-1];
  addr_t                   last_pc;
  logic                    held_hit;
  logic                    ar_seen;
  logic                    hit_due;
  logic                    burst_active;
  axi_ar_t                 burst;
  int                      beat_cnt;
  logic                    prev_wait;
  fetch_rsp_t              prev_rsp;
  int                      accepted;
  int                      taken;
  int                      dropped;
  int                      bursts;

  icache_top #(.INDEX_W(INDEX_W)) uut (
    .clock        (clock),
    .reset        (reset),
    .req_valid_i  (req_valid),
    .req_i        (req),
    .req_ready_o  (req_ready),
    .rsp_valid_o  (rsp_valid),
    .rsp_o        (rsp),
    .rsp_ready_i  (rsp_ready),
    .flush_i      (flush),
    .invalidate_i (invalidate),
    .ar_valid_o   (ar_valid),
    .ar_o         (ar),
    .ar_ready_i   (ar_ready),
    .r_valid_i    (r_valid),
    .r_i          (r),
    .r_ready_o    (r_ready)
  );

  icache_mem_model u_mem (
    .clock      (clock),
    .reset      (reset),
    .ar_valid_i (ar_valid),
    .ar_i       (ar),
    .ar_ready_o (ar_ready),
    .r_valid_o  (r_valid),
    .r_o        (r),
    .r_ready_i  (r_ready)
  );

  function automatic logic uncached_addr(addr_t a);
    return a[31:16] == UNCACHED_HI;
  endfunction

  function automatic word_t mem_word(addr_t a);
    return {a[31:2], 2'b00} ^ DATA_KEY;
  endfunction

  function automatic logic [INDEX_W-1:0] index_of(addr_t a);
    return a[4 +: INDEX_W];
  endfunction

  function automatic logic [TAG_W-1:0] tag_of(addr_t a);
    return a[31 -: TAG_W];
  endfunction

  // 8 cached lines compete for 4 slots, a few uncached words on the side
  function automatic fetch_req_t random_fetch();
    fetch_req_t f;
    if ($urandom_range(9) < 2) begin
      f.pc = 32'h0f00_0000 + addr_t'($urandom_range(15) << 2);
    end else begin
      f.pc = 32'h0000_1000 + addr_t'($urandom_range(31) << 2);
    end
    f.snpc = f.pc + 32'd4;
    return f;
  endfunction

  task automatic expect_equal(input logic [95:0] got, input logic [95:0] want, input string what);
    if (got !== want) begin
      $display("Mismatch at %0t ns: %s (got %0h, expected %0h)", $time, what, got, want);
      $display("Test failed");
      $fatal(1, "stopping on first error");
    end
  endtask

  task automatic report_error(input string what);
    $display("Error at %0t ns: %s", $time, what);
    $display("Test failed");
    $fatal(1, "stopping on first error");
  endtask

  // everything here describes the transfers of the coming rising edge
  task automatic observe_edge();
    fetch_rsp_t want;
    fetch_req_t head;
    addr_t      beat_addr;
    logic       cached_hit;
    if (hit_due) begin
      expect_equal(96'(rsp_valid), 96'(1), "hit not answered the cycle after acceptance");
      hit_due = 1'b0;
    end
    if (prev_wait) begin
      expect_equal(96'(rsp_valid), 96'(1), "waiting response withdrawn");
      expect_equal(rsp, prev_rsp, "waiting response changed");
    end
    if (rsp_valid && !rsp_ready) begin
      expect_equal(96'(req_ready), 96'(0), "req_ready high while a response waits");
    end
    if (burst_active) begin
      expect_equal(96'(r_ready), 96'(1), "r_ready low in the data phase");
    end
    if (ar_valid && ar_ready) begin
      expect_equal(96'(ar.addr), 96'(last_pc), "burst address");
      expect_equal(96'(ar.len), uncached_addr(ar.addr) ? 96'(0) : 96'(3), "burst length");
      if (held_hit || burst_active) begin
        report_error("address transfer where none was expected");
      end
      ar_seen      = 1'b1;
      burst_active = 1'b1;
      burst        = ar;
      beat_cnt     = 0;
      bursts++;
    end
    if (r_valid && r_ready) begin
      beat_addr = {burst.addr[31:4], burst.addr[3:2] + 2'(beat_cnt), 2'b00};
      expect_equal(96'(r.data), 96'(mem_word(beat_addr)), "wrapped beat data");
      expect_equal(96'(r.last), 96'(beat_cnt == int'(burst.len)), "last beat position");
      if (r.last) begin
        burst_active = 1'b0;
        if (!uncached_addr(burst.addr)) begin
          shadow_valid[index_of(burst.addr)] = 1'b1;
          shadow_tag[index_of(burst.addr)]   = tag_of(burst.addr);
        end
      end
      beat_cnt++;
    end
    if (rsp_valid && rsp_ready) begin
      if (pend_q.size() == 0) begin
        report_error("response with no request pending");
      end else begin
        head      = pend_q.pop_front();
        want.pc   = head.pc;
        want.snpc = head.snpc;
        want.inst = mem_word(head.pc);
        expect_equal(rsp, want, "response");
        expect_equal(96'(ar_seen), 96'(!held_hit), "address transfer for this fetch");
        taken++;
      end
    end else if (flush && pend_q.size() != 0) begin
      head = pend_q.pop_front();
      dropped++;
    end
    // invalidate wins over a line finishing on the same edge
    if (invalidate) begin
      shadow_valid = '0;
      held_hit     = 1'b0;
    end
    if (req_valid && req_ready) begin
      if (pend_q.size() != 0) begin
        report_error("request accepted while another is pending");
      end else begin
        cached_hit = !uncached_addr(req.pc) && shadow_valid[index_of(req.pc)]
                     && (shadow_tag[index_of(req.pc)] == tag_of(req.pc));
        pend_q.push_back(req);
        last_pc  = req.pc;
        held_hit = cached_hit;
        hit_due  = cached_hit;
        ar_seen  = 1'b0;
        accepted++;
      end
    end
    prev_wait = rsp_valid && !rsp_ready && !flush && !invalidate;
    prev_rsp  = rsp;
  endtask

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  initial begin
    #(NUM_FETCHES * CYCLES_PER_FETCH * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d clock cycles",
             NUM_FETCHES * CYCLES_PER_FETCH);
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    forever begin
      @(negedge clock);
      if (!reset) begin
        observe_edge();
      end
    end
  end

  initial begin
    int seen;
    void'($urandom(34));
    reset        = 1'b1;
    req_valid    = 1'b0;
    req          = '0;
    rsp_ready    = 1'b0;
    flush        = 1'b0;
    invalidate   = 1'b0;
    shadow_valid = '0;
    last_pc      = '0;
    held_hit     = 1'b0;
    ar_seen      = 1'b0;
    hit_due      = 1'b0;
    burst_active = 1'b0;
    burst        = '0;
    beat_cnt     = 0;
    prev_wait    = 1'b0;
    prev_rsp     = '0;
    accepted     = 0;
    taken        = 0;
    dropped      = 0;
    bursts       = 0;
    seen         = 0;
    repeat (5) @(posedge clock);
    #2;
    reset = 1'b0;
    while (accepted < NUM_FETCHES) begin
      @(posedge clock);
      #2;
      // request held until accepted
      if (accepted != seen) begin
        seen      = accepted;
        req_valid = 1'b0;
      end
      if (!req_valid && accepted < NUM_FETCHES && $urandom_range(9) < 7) begin
        req_valid = 1'b1;
        req       = random_fetch();
      end
      rsp_ready  = ($urandom_range(3) != 0);
      flush      = ($urandom_range(24) == 0);
      invalidate = ($urandom_range(39) == 0);
    end
    req_valid  = 1'b0;
    flush      = 1'b0;
    invalidate = 1'b0;
    rsp_ready  = 1'b1;
    while (pend_q.size() != 0 || burst_active || ar_valid) begin
      @(posedge clock);
      #2;
    end
    // stage empty and refill idle once everything has drained
    expect_equal(96'(rsp_valid), 96'(0), "response still valid after the last fetch");
    expect_equal(96'(req_ready), 96'(1), "fetch side not ready after the last fetch");
    $display("fetches %0d, responses %0d, flushed %0d, bursts %0d",
             accepted, taken, dropped, bursts);
    $display("Test passed");
    $finish;
  end

endmodule
